// ==== verilog/core_pkg.sv ====
// widths, depths and shared types for the out-of-order integer core
// rob_depth has to be 2**rob_tag_bits so head and tail wrap on overflow
// only the OP and OP-IMM major opcodes are decoded

package core_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////

	// data path width
	localparam int xlen = 32;

	// reorder buffer entries and tag width
	localparam int rob_depth    = 8;
	localparam int rob_tag_bits = 3;

	// reservation station entries
	localparam int rs_depth = 4;

	//////////////////////////////
	// encodings
	//////////////////////////////

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011
	} opcode_t;

	// operations the single ALU knows
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_slt = 3'd5
	} alu_op_t;

	// life of one reorder buffer slot
	typedef enum logic [1:0] {
		rob_empty = 2'd0,
		rob_busy  = 2'd1,
		rob_done  = 2'd2
	} rob_state_t;

	// common data bus, one result per cycle
	typedef struct packed {
		logic                    valid;
		logic [rob_tag_bits-1:0] tag;
		logic [xlen-1:0]         value;
	} cdb_t;

endpackage

// ==== verilog/core_ifs.sv ====
// point-to-point links between the pipeline stages
// all three are strobes without a ready signal
// the receiver must take the item in the cycle valid is high

`timescale 1ns/1ns

//////////////////////////////
// issue to station and rob
//////////////////////////////

interface dispatch_if import core_pkg::*; ();
	logic                    valid;
	alu_op_t                 op;
	logic [4:0]              rd;
	logic [rob_tag_bits-1:0] tag;
	// operand a
	logic [xlen-1:0]         a_value;
	logic                    a_ready;
	logic [rob_tag_bits-1:0] a_tag;
	// operand b, already the immediate for ADDI
	logic [xlen-1:0]         b_value;
	logic                    b_ready;
	logic [rob_tag_bits-1:0] b_tag;

	modport source (output valid, op, rd, tag, a_value, a_ready, a_tag,
		b_value, b_ready, b_tag);
	modport sink (input valid, op, rd, tag, a_value, a_ready, a_tag,
		b_value, b_ready, b_tag);
endinterface

//////////////////////////////
// station to alu
//////////////////////////////

interface exec_if import core_pkg::*; ();
	logic                    valid;
	alu_op_t                 op;
	logic [xlen-1:0]         a;
	logic [xlen-1:0]         b;
	logic [rob_tag_bits-1:0] tag;

	modport source (output valid, op, a, b, tag);
	modport sink (input valid, op, a, b, tag);
endinterface

//////////////////////////////
// rob head to register file
//////////////////////////////

interface commit_if import core_pkg::*; ();
	logic                    valid;
	logic [4:0]              rd;
	logic [xlen-1:0]         value;
	logic [rob_tag_bits-1:0] tag;

	modport source (output valid, rd, value, tag);
	modport sink (input valid, rd, value, tag);
endinterface

// ==== verilog/issue_stage.sv ====
// decode, rename and dispatch of one instruction per cycle
// only supported encodings may be offered; there is no illegal path
// stall is taken from rs_full and rob_full as seen before any commit

`timescale 1ns/1ns

module issue_stage import core_pkg::*; (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    inst_valid,
	input  logic [31:0]             inst,
	output logic                    inst_ready,
	input  logic                    rs_full,
	input  logic                    rob_full,
	input  logic [rob_tag_bits-1:0] alloc_tag,
	output logic [rob_tag_bits-1:0] read_tag_a,
	output logic [rob_tag_bits-1:0] read_tag_b,
	input  logic [xlen-1:0]         read_value_a,
	input  logic [xlen-1:0]         read_value_b,
	input  logic                    read_done_a,
	input  logic                    read_done_b,
	input  cdb_t                    cdb,
	dispatch_if.source              dispatch,
	commit_if.sink                  commit
);

	// resolved source operand
	typedef struct packed {
		logic                    ready;
		logic [rob_tag_bits-1:0] tag;
		logic [xlen-1:0]         value;
	} operand_t;

	opcode_t    opcode;
	logic [4:0] rd, rs1, rs2;
	logic [2:0] funct3;
	logic       is_imm;
	logic [xlen-1:0] imm;
	alu_op_t    op;
	operand_t   src_a, src_b;

	// architectural state plus rename map
	logic [xlen-1:0]         regfile [32];
	logic [31:0]             map_valid;
	logic [rob_tag_bits-1:0] map_tag [32];

	// register file, then a done rob entry, then this cycle's bus
	function automatic operand_t resolve(input logic [xlen-1:0] rf_value,
		input logic mapped, input logic [rob_tag_bits-1:0] tag,
		input logic [xlen-1:0] rob_value, input logic rob_done, input cdb_t bus);
		operand_t res;
		res.tag   = tag;
		res.ready = 1'b1;
		res.value = rf_value;
		if (mapped) begin
			if (rob_done) begin
				res.value = rob_value;
			end else if (bus.valid && bus.tag == tag) begin
				res.value = bus.value;
			end else begin
				res.ready = 1'b0;
				res.value = '0;
			end
		end
		return res;
	endfunction

	//////////////////////////////
	// decode
	//////////////////////////////

	assign opcode = opcode_t'(inst[6:0]);
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign is_imm = (opcode == opc_op_imm);
	// I-type immediate, sign extended
	assign imm    = {{(xlen-12){inst[31]}}, inst[31:20]};

	always_comb begin
		op = alu_add;
		// ADDI is the only OP-IMM form
		if (!is_imm) begin
			case (funct3)
				3'b000: op = inst[30] ? alu_sub : alu_add;
				3'b010: op = alu_slt;
				3'b100: op = alu_xor;
				3'b110: op = alu_or;
				3'b111: op = alu_and;
				default: op = alu_add;
			endcase
		end
	end

	//////////////////////////////
	// operand read
	//////////////////////////////

	assign read_tag_a = map_tag[rs1];
	assign read_tag_b = map_tag[rs2];

	assign src_a = resolve(regfile[rs1], map_valid[rs1], map_tag[rs1],
		read_value_a, read_done_a, cdb);
	assign src_b = resolve(regfile[rs2], map_valid[rs2], map_tag[rs2],
		read_value_b, read_done_b, cdb);

	// back-pressure, dispatch in the accept edge
	assign inst_ready = !rob_full && !rs_full;

	assign dispatch.valid   = inst_valid && inst_ready;
	assign dispatch.op      = op;
	assign dispatch.rd      = rd;
	assign dispatch.tag     = alloc_tag;
	assign dispatch.a_value = src_a.value;
	assign dispatch.a_ready = src_a.ready;
	assign dispatch.a_tag   = src_a.tag;
	assign dispatch.b_value = is_imm ? imm : src_b.value;
	assign dispatch.b_ready = is_imm || src_b.ready;
	assign dispatch.b_tag   = src_b.tag;

	//////////////////////////////
	// register file and map
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			map_valid <= '0;
			for (int i = 0; i < 32; i++) begin
				regfile[i] <= '0;
				map_tag[i] <= '0;
			end
		end else begin
			// commit retires into x1..x31, x0 stays zero
			if (commit.valid && commit.rd != 5'd0) begin
				regfile[commit.rd] <= commit.value;
				// a younger producer keeps its mapping
				if (map_valid[commit.rd] && map_tag[commit.rd] == commit.tag) begin
					map_valid[commit.rd] <= 1'b0;
				end
			end
			// new producer wins over a same-cycle clear
			if (dispatch.valid && rd != 5'd0) begin
				map_valid[rd] <= 1'b1;
				map_tag[rd]   <= alloc_tag;
			end
		end
	end

endmodule

// ==== verilog/reservation_station.sv ====
// single reservation station in front of the ALU
// oldest ready entry goes to the ALU, ordered by an age matrix
// a slot freed by issue is reusable from the following cycle on

`timescale 1ns/1ns

module reservation_station import core_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	dispatch_if.sink   dispatch,
	input  cdb_t       cdb,
	exec_if.source     exec,
	output logic       rs_full
);

	// entry state
	logic [rs_depth-1:0]     valid;
	logic [rs_depth-1:0]     older [rs_depth];
	alu_op_t                 op_q [rs_depth];
	logic [rob_tag_bits-1:0] tag_q [rs_depth];
	logic [xlen-1:0]         a_val [rs_depth];
	logic [xlen-1:0]         b_val [rs_depth];
	logic [rs_depth-1:0]     a_rdy;
	logic [rs_depth-1:0]     b_rdy;
	logic [rob_tag_bits-1:0] a_tag [rs_depth];
	logic [rob_tag_bits-1:0] b_tag [rs_depth];

	logic [rs_depth-1:0]         ready;
	logic                        is_oldest;
	logic                        sel_valid;
	logic [$clog2(rs_depth)-1:0] sel_idx;
	logic [$clog2(rs_depth)-1:0] alloc_idx;
	logic                        a_hit, b_hit;

	assign rs_full = &valid;
	assign ready   = valid & a_rdy & b_rdy;

	// bus result arriving with the dispatch
	assign a_hit = cdb.valid && cdb.tag == dispatch.a_tag;
	assign b_hit = cdb.valid && cdb.tag == dispatch.b_tag;

	//////////////////////////////
	// select and allocate
	//////////////////////////////

	// older[j][i] set means j entered before i
	always_comb begin
		sel_valid = 1'b0;
		sel_idx   = '0;
		is_oldest = 1'b0;
		for (int i = 0; i < rs_depth; i++) begin
			is_oldest = ready[i];
			for (int j = 0; j < rs_depth; j++) begin
				if (ready[j] && older[j][i]) begin
					is_oldest = 1'b0;
				end
			end
			if (is_oldest && !sel_valid) begin
				sel_valid = 1'b1;
				sel_idx   = i[$clog2(rs_depth)-1:0];
			end
		end
	end

	// lowest free slot
	always_comb begin
		alloc_idx = '0;
		for (int i = rs_depth - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				alloc_idx = i[$clog2(rs_depth)-1:0];
			end
		end
	end

	assign exec.valid = sel_valid;
	assign exec.op    = op_q[sel_idx];
	assign exec.a     = a_val[sel_idx];
	assign exec.b     = b_val[sel_idx];
	assign exec.tag   = tag_q[sel_idx];

	//////////////////////////////
	// occupancy and age
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
			for (int i = 0; i < rs_depth; i++) begin
				older[i] <= '0;
			end
		end else begin
			if (sel_valid) begin
				valid[sel_idx] <= 1'b0;
			end
			if (dispatch.valid) begin
				valid[alloc_idx] <= 1'b1;
				// everyone present is older than the newcomer
				older[alloc_idx] <= '0;
				for (int j = 0; j < rs_depth; j++) begin
					older[j][alloc_idx] <= valid[j];
				end
			end
		end
	end

	//////////////////////////////
	// payload and wake-up
	//////////////////////////////

	always_ff @(posedge clock) begin
		// snoop the bus for waiting operands
		for (int i = 0; i < rs_depth; i++) begin
			if (valid[i] && !a_rdy[i] && cdb.valid && cdb.tag == a_tag[i]) begin
				a_val[i] <= cdb.value;
				a_rdy[i] <= 1'b1;
			end
			if (valid[i] && !b_rdy[i] && cdb.valid && cdb.tag == b_tag[i]) begin
				b_val[i] <= cdb.value;
				b_rdy[i] <= 1'b1;
			end
		end
		if (dispatch.valid) begin
			op_q[alloc_idx]  <= dispatch.op;
			tag_q[alloc_idx] <= dispatch.tag;
			a_tag[alloc_idx] <= dispatch.a_tag;
			b_tag[alloc_idx] <= dispatch.b_tag;
			a_rdy[alloc_idx] <= dispatch.a_ready || a_hit;
			b_rdy[alloc_idx] <= dispatch.b_ready || b_hit;
			a_val[alloc_idx] <= dispatch.a_ready ? dispatch.a_value : cdb.value;
			b_val[alloc_idx] <= dispatch.b_ready ? dispatch.b_value : cdb.value;
		end
	end

endmodule

// ==== verilog/alu_stage.sv ====
// one-cycle ALU, accepts every cycle
// result is registered and is the only driver of the bus

`timescale 1ns/1ns

module alu_stage import core_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	exec_if.sink  exec,
	output cdb_t  cdb
);

	logic [xlen-1:0] result;
	logic            less;

	// signed compare for SLT
	assign less = $signed(exec.a) < $signed(exec.b);

	always_comb begin
		case (exec.op)
			alu_add: result = exec.a + exec.b;
			alu_sub: result = exec.a - exec.b;
			alu_and: result = exec.a & exec.b;
			alu_or:  result = exec.a | exec.b;
			alu_xor: result = exec.a ^ exec.b;
			alu_slt: result = {{(xlen-1){1'b0}}, less};
			default: result = '0;
		endcase
	end

	// bus register, only valid is cleared
	always_ff @(posedge clock) begin
		if (reset) begin
			cdb.valid <= 1'b0;
		end else begin
			cdb.valid <= exec.valid;
		end
		cdb.tag   <= exec.tag;
		cdb.value <= result;
	end

endmodule

// ==== verilog/reorder_buffer.sv ====
// circular reorder buffer, allocates at tail and commits at head
// at most one commit per cycle, commit_if is valid while the head is done
// rob_full is the level before this cycle's commit

`timescale 1ns/1ns

module reorder_buffer import core_pkg::*; (
	input  logic                    clock,
	input  logic                    reset,
	dispatch_if.sink                dispatch,
	input  cdb_t                    cdb,
	output logic                    rob_full,
	output logic [rob_tag_bits-1:0] alloc_tag,
	input  logic [rob_tag_bits-1:0] read_tag_a,
	input  logic [rob_tag_bits-1:0] read_tag_b,
	output logic [xlen-1:0]         read_value_a,
	output logic [xlen-1:0]         read_value_b,
	output logic                    read_done_a,
	output logic                    read_done_b,
	commit_if.source                commit
);

	// entry storage
	rob_state_t      state [rob_depth];
	logic [4:0]      rd_q [rob_depth];
	logic [xlen-1:0] value_q [rob_depth];

	// pointers
	logic [rob_tag_bits-1:0] head;
	logic [rob_tag_bits-1:0] tail;
	logic [rob_tag_bits:0]   count;

	assign rob_full  = (count == (rob_tag_bits + 1)'(rob_depth));
	assign alloc_tag = tail;

	//////////////////////////////
	// lookups for issue
	//////////////////////////////

	assign read_value_a = value_q[read_tag_a];
	assign read_value_b = value_q[read_tag_b];
	assign read_done_a  = (state[read_tag_a] == rob_done);
	assign read_done_b  = (state[read_tag_b] == rob_done);

	//////////////////////////////
	// commit port
	//////////////////////////////

	assign commit.valid = (state[head] == rob_done);
	assign commit.rd    = rd_q[head];
	assign commit.value = value_q[head];
	assign commit.tag   = head;

	// control state
	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			for (int i = 0; i < rob_depth; i++) begin
				state[i] <= rob_empty;
			end
		end else begin
			// new entry at tail, never full here
			if (dispatch.valid) begin
				state[tail] <= rob_busy;
				tail        <= tail + 1'b1;
			end
			// bus only names busy entries
			if (cdb.valid) begin
				state[cdb.tag] <= rob_done;
			end
			// retire the head
			if (commit.valid) begin
				state[head] <= rob_empty;
				head        <= head + 1'b1;
			end
			case ({dispatch.valid, commit.valid})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// payload without reset
	always_ff @(posedge clock) begin
		if (dispatch.valid) begin
			rd_q[tail] <= dispatch.rd;
		end
		if (cdb.valid) begin
			value_q[cdb.tag] <= cdb.value;
		end
	end

endmodule

// ==== verilog/ooo_core.sv ====
// top of the out-of-order integer core
// instructions come in on a valid/ready pair, results leave at commit
// commit_valid pulses once per retired instruction, x0 writes included

`timescale 1ns/1ns

module ooo_core import core_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  logic            inst_valid,
	input  logic [31:0]     inst,
	output logic            inst_ready,
	output logic            commit_valid,
	output logic [4:0]      commit_rd,
	output logic [xlen-1:0] commit_data
);

	dispatch_if dispatch_bus ();
	exec_if     exec_bus ();
	commit_if   commit_bus ();

	// common data bus
	cdb_t cdb;

	// station and rob status back to issue
	logic                    rs_full;
	logic                    rob_full;
	logic [rob_tag_bits-1:0] alloc_tag;
	logic [rob_tag_bits-1:0] read_tag_a, read_tag_b;
	logic [xlen-1:0]         read_value_a, read_value_b;
	logic                    read_done_a, read_done_b;

	assign commit_valid = commit_bus.valid;
	assign commit_rd    = commit_bus.rd;
	assign commit_data  = commit_bus.value;

	//////////////////////////////
	// stages
	//////////////////////////////

	issue_stage issue_0 (
		.clock        (clock),
		.reset        (reset),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.inst_ready   (inst_ready),
		.rs_full      (rs_full),
		.rob_full     (rob_full),
		.alloc_tag    (alloc_tag),
		.read_tag_a   (read_tag_a),
		.read_tag_b   (read_tag_b),
		.read_value_a (read_value_a),
		.read_value_b (read_value_b),
		.read_done_a  (read_done_a),
		.read_done_b  (read_done_b),
		.cdb          (cdb),
		.dispatch     (dispatch_bus.source),
		.commit       (commit_bus.sink)
	);

	reservation_station rs_0 (
		.clock    (clock),
		.reset    (reset),
		.dispatch (dispatch_bus.sink),
		.cdb      (cdb),
		.exec     (exec_bus.source),
		.rs_full  (rs_full)
	);

	alu_stage alu_0 (
		.clock (clock),
		.reset (reset),
		.exec  (exec_bus.sink),
		.cdb   (cdb)
	);

	reorder_buffer rob_0 (
		.clock        (clock),
		.reset        (reset),
		.dispatch     (dispatch_bus.sink),
		.cdb          (cdb),
		.rob_full     (rob_full),
		.alloc_tag    (alloc_tag),
		.read_tag_a   (read_tag_a),
		.read_tag_b   (read_tag_b),
		.read_value_a (read_value_a),
		.read_value_b (read_value_b),
		.read_done_a  (read_done_a),
		.read_done_b  (read_done_b),
		.commit       (commit_bus.source)
	);

endmodule

// ==== sim/ooo_core_asserts.sv ====
// concurrent checks on the reorder buffer, bound into reorder_buffer
// count is compared against the full depth, not the tag range

`timescale 1ns/1ns

module ooo_core_asserts import core_pkg::*; (
	input logic                  clock,
	input logic                  reset,
	input logic [rob_tag_bits:0] count,
	input logic                  rob_full,
	input logic                  dispatch_valid,
	input logic                  commit_valid
);

	// occupancy bound
	property count_in_range;
		@(posedge clock) disable iff (reset) count <= (rob_tag_bits + 1)'(rob_depth);
	endproperty

	// issue must stall on a full rob
	property no_dispatch_when_full;
		@(posedge clock) disable iff (reset) rob_full |-> !dispatch_valid;
	endproperty

	property commit_known;
		@(posedge clock) disable iff (reset) !$isunknown(commit_valid);
	endproperty

	assert property (count_in_range) else $error("reorder buffer count above depth");
	assert property (no_dispatch_when_full) else $error("dispatch while reorder buffer full");
	assert property (commit_known) else $error("commit valid unknown after reset");

endmodule

bind reorder_buffer ooo_core_asserts asserts_0 (
	.clock          (clock),
	.reset          (reset),
	.count          (count),
	.rob_full       (rob_full),
	.dispatch_valid (dispatch.valid),
	.commit_valid   (commit.valid)
);

// ==== sim/ooo_core_tb.sv ====
// testbench for the out-of-order core
// random program from an LCG with seed 8060
// registers x0..x7 only, so dependencies are dense
// expected commits come from an in-order model run at each accept edge
// x0 writes are checked for rd only and the model drops their value

`timescale 1ns/1ns

module ooo_core_tb import core_pkg::*; ();

	localparam int n_inst         = 2000;
	localparam int clock_period   = 10;
	localparam int reset_cycles   = 8;
	localparam int watchdog_limit = (reset_cycles + n_inst * 20) * clock_period;

	// instruction kinds of the subset
	localparam int kind_add  = 0;
	localparam int kind_sub  = 1;
	localparam int kind_and  = 2;
	localparam int kind_or   = 3;
	localparam int kind_xor  = 4;
	localparam int kind_slt  = 5;
	localparam int kind_addi = 6;

	logic            clock = 1'b0;
	logic            reset;
	logic            inst_valid;
	logic [31:0]     inst;
	logic            inst_ready;
	logic            commit_valid;
	logic [4:0]      commit_rd;
	logic [xlen-1:0] commit_data;

	// current offer held until accepted
	int          cur_kind;
	logic [4:0]  cur_rd, cur_rs1, cur_rs2;
	logic [11:0] cur_imm;
	logic        pending;
	logic        burst;

	// in-order model and expected commit queue
	logic [xlen-1:0] model_regs [32];
	logic [4:0]      exp_rd [$];
	logic [xlen-1:0] exp_value [$];

	logic [31:0] rand_state;
	int          accepts;
	int          commits;
	int          stalls;
	int          cycle;

	ooo_core ooo_core_i (
		.clock        (clock),
		.reset        (reset),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.inst_ready   (inst_ready),
		.commit_valid (commit_valid),
		.commit_rd    (commit_rd),
		.commit_data  (commit_data)
	);

	always #(clock_period / 2) clock = ~clock;

	//////////////////////////////
	// helpers
	//////////////////////////////

	// LCG step taking the upper bits
	function automatic int unsigned rand_below(input int unsigned n);
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state[30:16] % n;
	endfunction

	// RV32I R-type or I-type word
	function automatic logic [31:0] encode(input int kind, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] imm);
		logic [6:0] funct7;
		logic [2:0] funct3;
		funct7 = 7'b0000000;
		case (kind)
			kind_sub: begin
				funct3 = 3'b000;
				funct7 = 7'b0100000;
			end
			kind_and: funct3 = 3'b111;
			kind_or:  funct3 = 3'b110;
			kind_xor: funct3 = 3'b100;
			kind_slt: funct3 = 3'b010;
			default:  funct3 = 3'b000;
		endcase
		if (kind == kind_addi) begin
			return {imm, rs1, 3'b000, rd, 7'b0010011};
		end
		return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
	endfunction

	// architectural result of one instruction
	function automatic logic [31:0] reference_result(input int kind, input logic [31:0] a,
		input logic [31:0] b, input logic [11:0] imm);
		case (kind)
			kind_add: return a + b;
			kind_sub: return a - b;
			kind_and: return a & b;
			kind_or:  return a | b;
			kind_xor: return a ^ b;
			kind_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default:  return a + {{20{imm[11]}}, imm};
		endcase
	endfunction

	task automatic stop_with_failure();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped after a failed check");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic new_instruction();
		cur_kind = rand_below(7);
		cur_rd   = 5'(rand_below(8));
		cur_rs1  = 5'(rand_below(8));
		cur_rs2  = 5'(rand_below(8));
		cur_imm  = 12'(rand_below(4096));
		inst     = encode(cur_kind, cur_rd, cur_rs1, cur_rs2, cur_imm);
	endtask

	// run the accepted instruction in program order
	task automatic accept_model();
		logic [31:0] res;
		res = reference_result(cur_kind, model_regs[cur_rs1], model_regs[cur_rs2], cur_imm);
		if (cur_rd != 5'd0) begin
			model_regs[cur_rd] = res;
		end
		exp_rd.push_back(cur_rd);
		exp_value.push_back(res);
	endtask

	//////////////////////////////
	// stimulus and drain
	//////////////////////////////

	initial begin
		reset      = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		pending    = 1'b0;
		burst      = 1'b0;
		rand_state = 32'd8060;
		accepts    = 0;
		stalls     = 0;
		cycle      = 0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		check_value("commit_valid", {31'd0, commit_valid}, 32'd0);
		check_value("inst_ready", {31'd0, inst_ready}, 32'd1);

		while (accepts < n_inst) begin
			// long bursts fill the station and the rob
			if (cycle % 40 == 0) begin
				burst = (rand_below(2) == 0);
			end
			if (!pending && (burst || rand_below(2) == 0)) begin
				new_instruction();
				pending = 1'b1;
			end
			inst_valid = pending;
			cycle++;
			@(posedge clock);
			if (inst_valid && inst_ready) begin
				accept_model();
				pending = 1'b0;
				accepts++;
			end else if (inst_valid) begin
				stalls++;
			end
			@(negedge clock);
		end
		inst_valid = 1'b0;

		// wait for every commit and a few more cycles for a surplus one
		while (commits < accepts) begin
			@(posedge clock);
		end
		repeat (10) @(posedge clock);
		if (stalls == 0) begin
			$display("inst_ready never dropped during the bursts");
			stop_with_failure();
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

	//////////////////////////////
	// commit checker
	//////////////////////////////

	initial begin
		commits = 0;
	end

	always @(posedge clock) begin
		if (!reset && commit_valid) begin
			if (exp_rd.size() == 0) begin
				$display("a commit arrived with no accepted instruction outstanding");
				stop_with_failure();
			end else begin
				check_value("commit_rd", {27'd0, commit_rd}, {27'd0, exp_rd[0]});
				// x0 result is dropped by the model
				if (exp_rd[0] != 5'd0) begin
					check_value("commit_data", commit_data, exp_value[0]);
				end
				void'(exp_rd.pop_front());
				void'(exp_value.pop_front());
				commits++;
			end
		end
	end

	// watchdog
	initial begin
		#(watchdog_limit);
		$display("watchdog expired before all accepted instructions committed");
		stop_with_failure();
	end

endmodule

// ==== sources.f ====
verilog/core_pkg.sv
verilog/core_ifs.sv
verilog/issue_stage.sv
verilog/reservation_station.sv
verilog/alu_stage.sv
verilog/reorder_buffer.sv
verilog/ooo_core.sv
sim/ooo_core_asserts.sv
sim/ooo_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module ooo_core_tb -f sources.f -o ooo_core_sim

# a failing run stops with a nonzero status, the output decides
output=$(./obj_dir/ooo_core_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
